// File: design/rv_exec_settings.svh
`ifndef RV_EXEC_SETTINGS_SVH
`define RV_EXEC_SETTINGS_SVH

// architectural sizes
`define RV_NREGS        32
`define RV_RESET_PC     32'h0000_0000

// apb address map, 12-bit byte addresses
`define RV_A_INSTR      12'h000
`define RV_A_PC         12'h004
`define RV_A_CSR        12'h008
`define RV_A_ST_ADDR    12'h00C
`define RV_A_ST_DATA    12'h010
`define RV_A_ST_MASK    12'h014

// x0..x31 mapped word by word from here
`define RV_A_REG_BASE   12'h080

// csr funct3 codes accepted on SYSTEM
`define RV_F3_CSRRW     3'b001
`define RV_F3_CSRRS     3'b010

`endif

// File: design/rv_exec_pkg.sv
`default_nettype none

package rv_exec_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_idx_t;

	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_STORE  = 7'b0100011,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011,
		OPC_SYSTEM = 7'b1110011
	} opcode_t;

	typedef enum logic [2:0] {
		FMT_R, FMT_I, FMT_S, FMT_B, FMT_U, FMT_J
	} fmt_t;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_XOR, ALU_OR,
		ALU_SRL, ALU_SRA, ALU_SLL, ALU_LESS, ALU_ULESS
	} alu_op_t;

	typedef struct packed {
		word_t      addr;
		word_t      data; // rs2 as is, not lane shifted
		logic [3:0] mask;
	} store_rec_t;

	typedef struct packed {
		opcode_t    opcode;
		fmt_t       fmt;
		logic [2:0] funct3;
		logic       f7b5;   // instr[30]
		reg_idx_t   rd;
		reg_idx_t   rs1;
		reg_idx_t   rs2;
		word_t      imm;    // sign extended
		logic       illegal;
	} decoded_t;

	typedef struct packed {
		reg_idx_t   rd;
		logic       rd_we;
		word_t      result;
		word_t      next_pc;
		logic       st_en;
		store_rec_t st;
		logic       csr_we;
		word_t      csr_wdata;
	} exec_res_t;

endpackage

`default_nettype wire

// File: design/key_mux.sv
`timescale 1ns/1ns
`default_nettype none

module key_mux #(
	parameter int  N      = 2,
	parameter int  KEY_W  = 1,
	parameter type data_t = logic
) (
	input  logic [KEY_W-1:0]        key,
	input  logic [N-1:0][KEY_W-1:0] keys,
	input  data_t [N-1:0]           values,
	input  data_t                   default_value,
	output data_t                   out
);

	// walk downwards so the lowest matching entry wins
	always_comb begin
		out = default_value;
		for (int i = N - 1; i >= 0; i--) begin
			if (keys[i] == key) begin
				out = values[i];
			end
		end
	end

endmodule

`default_nettype wire

// File: design/instr_decode.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_exec_settings.svh"

module instr_decode (
	input  rv_exec_pkg::word_t    instr,
	output rv_exec_pkg::decoded_t dec
);

	rv_exec_pkg::word_t imm_i;
	rv_exec_pkg::word_t imm_s;
	rv_exec_pkg::word_t imm_b;
	rv_exec_pkg::word_t imm_u;
	rv_exec_pkg::word_t imm_j;

	assign imm_i = {{21{instr[31]}}, instr[30:20]};
	assign imm_s = {{21{instr[31]}}, instr[30:25], instr[11:7]};
	assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		dec.opcode  = rv_exec_pkg::opcode_t'(instr[6:0]);
		dec.funct3  = instr[14:12];
		dec.f7b5    = instr[30];
		dec.rd      = instr[11:7];
		dec.rs1     = instr[19:15];
		dec.rs2     = instr[24:20];
		dec.illegal = 1'b0;
		dec.fmt     = rv_exec_pkg::FMT_I;

		case (dec.opcode)
			rv_exec_pkg::OPC_OP: begin
				dec.fmt = rv_exec_pkg::FMT_R;
			end
			rv_exec_pkg::OPC_OP_IMM, rv_exec_pkg::OPC_JALR: begin
				dec.fmt = rv_exec_pkg::FMT_I;
			end
			rv_exec_pkg::OPC_SYSTEM: begin
				dec.fmt = rv_exec_pkg::FMT_I; // csr address sits in the i field
				dec.illegal = (dec.funct3 != `RV_F3_CSRRW) && (dec.funct3 != `RV_F3_CSRRS);
			end
			rv_exec_pkg::OPC_STORE: begin
				dec.fmt = rv_exec_pkg::FMT_S;
			end
			rv_exec_pkg::OPC_BRANCH: begin
				dec.fmt = rv_exec_pkg::FMT_B;
			end
			rv_exec_pkg::OPC_LUI, rv_exec_pkg::OPC_AUIPC: begin
				dec.fmt = rv_exec_pkg::FMT_U;
			end
			rv_exec_pkg::OPC_JAL: begin
				dec.fmt = rv_exec_pkg::FMT_J;
			end
			default: begin
				dec.illegal = 1'b1; // loads, fences and the rest
			end
		endcase

		case (dec.fmt)
			rv_exec_pkg::FMT_S: dec.imm = imm_s;
			rv_exec_pkg::FMT_B: dec.imm = imm_b;
			rv_exec_pkg::FMT_U: dec.imm = imm_u;
			rv_exec_pkg::FMT_J: dec.imm = imm_j;
			rv_exec_pkg::FMT_R: dec.imm = '0;
			default:            dec.imm = imm_i;
		endcase
	end

endmodule

`default_nettype wire

// File: design/alu_execute.sv
`timescale 1ns/1ns
`default_nettype none

module alu_execute (
	input  rv_exec_pkg::decoded_t  dec,
	input  rv_exec_pkg::word_t     pc,
	input  rv_exec_pkg::word_t     rs1_val,
	input  rv_exec_pkg::word_t     rs2_val,
	input  rv_exec_pkg::word_t     csr_val,
	output rv_exec_pkg::exec_res_t res
);

	rv_exec_pkg::word_t   lop, rop, alu_val, csr_wdata, target;
	rv_exec_pkg::alu_op_t op_f3, op_as, op_sr, alu_op;
	rv_exec_pkg::word_t   a_diff, b_diff;
	logic                 a_borrow, a_less, b_borrow, b_less, b_ne;
	logic                 br_cond, is_jal, is_jalr, is_br, is_sys, is_st, take, wr_rd;
	logic [3:0]           st_mask;

	assign is_jal  = dec.opcode == rv_exec_pkg::OPC_JAL;
	assign is_jalr = dec.opcode == rv_exec_pkg::OPC_JALR;
	assign is_br   = dec.opcode == rv_exec_pkg::OPC_BRANCH;
	assign is_sys  = dec.opcode == rv_exec_pkg::OPC_SYSTEM;
	assign is_st   = dec.opcode == rv_exec_pkg::OPC_STORE;

	always_comb begin
		case (dec.opcode)
			rv_exec_pkg::OPC_LUI:   lop = '0;
			rv_exec_pkg::OPC_AUIPC,
			rv_exec_pkg::OPC_JAL,
			rv_exec_pkg::OPC_JALR:  lop = pc; // link = pc + 4
			default:                lop = rs1_val;
		endcase
	end

	key_mux #(.N(3), .KEY_W(7), .data_t(rv_exec_pkg::word_t)) rop_mux (
		.key(dec.opcode),
		.keys('{rv_exec_pkg::OPC_OP, rv_exec_pkg::OPC_JAL, rv_exec_pkg::OPC_JALR}),
		.values('{rs2_val, 32'd4, 32'd4}),
		.default_value(dec.imm),
		.out(rop)
	);

	assign op_as  = (dec.fmt == rv_exec_pkg::FMT_R && dec.f7b5) ? rv_exec_pkg::ALU_SUB
		: rv_exec_pkg::ALU_ADD;
	assign op_sr  = dec.f7b5 ? rv_exec_pkg::ALU_SRA : rv_exec_pkg::ALU_SRL;
	assign alu_op = (dec.fmt == rv_exec_pkg::FMT_I || dec.fmt == rv_exec_pkg::FMT_R) ? op_f3
		: rv_exec_pkg::ALU_ADD;

	key_mux #(.N(8), .KEY_W(3), .data_t(rv_exec_pkg::alu_op_t)) op_mux (
		.key(dec.funct3),
		.keys('{3'd7, 3'd6, 3'd5, 3'd4, 3'd3, 3'd2, 3'd1, 3'd0}),
		.values('{rv_exec_pkg::ALU_AND, rv_exec_pkg::ALU_OR, op_sr, rv_exec_pkg::ALU_XOR,
			rv_exec_pkg::ALU_ULESS, rv_exec_pkg::ALU_LESS, rv_exec_pkg::ALU_SLL, op_as}),
		.default_value(rv_exec_pkg::ALU_ADD),
		.out(op_f3)
	);

	assign {a_borrow, a_diff} = {1'b0, lop} - {1'b0, rop};
	assign a_less = (lop[31] ^ rop[31]) ? lop[31] : a_diff[31];

	key_mux #(.N(10), .KEY_W(4), .data_t(rv_exec_pkg::word_t)) val_mux (
		.key(alu_op),
		.keys('{rv_exec_pkg::ALU_ADD, rv_exec_pkg::ALU_SUB, rv_exec_pkg::ALU_AND,
			rv_exec_pkg::ALU_XOR, rv_exec_pkg::ALU_OR, rv_exec_pkg::ALU_SRL,
			rv_exec_pkg::ALU_SRA, rv_exec_pkg::ALU_SLL, rv_exec_pkg::ALU_LESS,
			rv_exec_pkg::ALU_ULESS}),
		.values('{lop + rop, a_diff, lop & rop, lop ^ rop, lop | rop, lop >> rop[4:0],
			rv_exec_pkg::word_t'($signed(lop) >>> rop[4:0]), lop << rop[4:0],
			{31'b0, a_less}, {31'b0, a_borrow}}),
		.default_value('0),
		.out(alu_val)
	);

	// branch compare, one subtractor
	assign {b_borrow, b_diff} = {1'b0, rs1_val} - {1'b0, rs2_val};
	assign b_less = (rs1_val[31] ^ rs2_val[31]) ? rs1_val[31] : b_diff[31];
	assign b_ne   = |b_diff;

	key_mux #(.N(6), .KEY_W(3), .data_t(logic)) br_mux (
		.key(dec.funct3),
		.keys('{3'b111, 3'b110, 3'b101, 3'b100, 3'b001, 3'b000}),
		.values('{~b_borrow, b_borrow, ~b_less, b_less, b_ne, ~b_ne}),
		.default_value(1'b0),
		.out(br_cond)
	);

	key_mux #(.N(3), .KEY_W(2), .data_t(logic [3:0])) mask_mux (
		.key(dec.funct3[1:0]),
		.keys('{2'b10, 2'b01, 2'b00}),
		.values('{4'hf, 4'h3, 4'h1}), // sw sh sb
		.default_value(4'h0),
		.out(st_mask)
	);

	key_mux #(.N(2), .KEY_W(3), .data_t(rv_exec_pkg::word_t)) csr_mux (
		.key(dec.funct3),
		.keys('{3'b010, 3'b001}),
		.values('{rs1_val | csr_val, rs1_val}),
		.default_value(csr_val),
		.out(csr_wdata)
	);

	assign take   = is_jal | is_jalr | (is_br & br_cond);
	assign target = is_jalr ? ((rs1_val + dec.imm) & ~32'h1) : pc + dec.imm;
	assign wr_rd  = !(is_br || is_st);

	always_comb begin
		res.rd        = dec.rd;
		res.rd_we     = wr_rd & ~dec.illegal;
		res.result    = is_sys ? csr_val : alu_val; // csr ops return the old value
		res.next_pc   = take ? target : pc + 32'd4;
		res.st_en     = is_st & ~dec.illegal;
		res.st.addr   = rs1_val + dec.imm;
		res.st.data   = rs2_val;
		res.st.mask   = st_mask;
		res.csr_we    = is_sys & ~dec.illegal;
		res.csr_wdata = csr_wdata;
	end

endmodule

`default_nettype wire

// File: design/result_commit.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_exec_settings.svh"

module result_commit (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    commit,
	input  rv_exec_pkg::exec_res_t  res,
	input  logic                    pc_load,
	input  rv_exec_pkg::word_t      pc_wdata,
	input  rv_exec_pkg::reg_idx_t   rs1_idx,
	input  rv_exec_pkg::reg_idx_t   rs2_idx,
	input  rv_exec_pkg::reg_idx_t   rd_idx_rd,
	output rv_exec_pkg::word_t      rs1_val,
	output rv_exec_pkg::word_t      rs2_val,
	output rv_exec_pkg::word_t      rd_val,
	output rv_exec_pkg::word_t      pc,
	output rv_exec_pkg::word_t      csr,
	output rv_exec_pkg::store_rec_t store
);

	rv_exec_pkg::word_t regs [`RV_NREGS];

	// register file with x0 held at zero
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `RV_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (commit && res.rd_we && res.rd != '0) begin
			regs[res.rd] <= res.result;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc    <= `RV_RESET_PC;
			csr   <= '0;
			store <= '0;
		end else begin
			if (pc_load) begin
				pc <= pc_wdata; // host write wins
			end else if (commit) begin
				pc <= res.next_pc;
			end
			if (commit && res.csr_we) begin
				csr <= res.csr_wdata;
			end
			if (commit && res.st_en) begin
				store <= res.st;
			end
		end
	end

	assign rs1_val = regs[rs1_idx];
	assign rs2_val = regs[rs2_idx];
	assign rd_val  = regs[rd_idx_rd];

endmodule

`default_nettype wire

// File: design/rv_exec_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_exec_settings.svh"

module rv_exec_top (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  logic [11:0]        paddr,
	input  rv_exec_pkg::word_t pwdata,
	output rv_exec_pkg::word_t prdata,
	output logic               pready,
	output logic               pslverr
);

	rv_exec_pkg::word_t     instr_q, rs1_q, rs2_q, csr_q;
	rv_exec_pkg::word_t     rs1_val, rs2_val, rd_val, pc, csr;
	rv_exec_pkg::decoded_t  dec, dec_q;
	rv_exec_pkg::exec_res_t res, res_q;
	rv_exec_pkg::store_rec_t store;
	logic                   v_dec, v_exe, v_com;
	logic                   access, instr_wr, in_regs;
	logic [11:0]            reg_off;

	assign access   = psel & penable;
	assign instr_wr = pwrite && (paddr == `RV_A_INSTR);

	// one bit per stage, shifted along the access phase
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			v_dec <= 1'b0;
			v_exe <= 1'b0;
			v_com <= 1'b0;
		end else begin
			v_dec <= psel & ~penable & instr_wr; // setup phase
			v_exe <= v_dec;
			v_com <= v_exe;
		end
	end

	always_ff @(posedge clk) begin
		if (psel && !penable && instr_wr) begin
			instr_q <= pwdata;
		end
		if (v_dec) begin
			dec_q <= dec;
			rs1_q <= rs1_val;
			rs2_q <= rs2_val;
			csr_q <= csr;
		end
		if (v_exe) begin
			res_q <= res;
		end
	end

	instr_decode decode_i (.instr(instr_q), .dec(dec));

	alu_execute execute_i (
		.dec(dec_q), .pc(pc), .rs1_val(rs1_q), .rs2_val(rs2_q), .csr_val(csr_q), .res(res)
	);

	assign reg_off = paddr - `RV_A_REG_BASE;
	assign in_regs = (paddr >= `RV_A_REG_BASE) && (reg_off < 12'(4 * `RV_NREGS));

	result_commit commit_i (
		.clk(clk), .arst_n(arst_n),
		.commit(v_com & ~dec_q.illegal),
		.res(res_q),
		.pc_load(access && pwrite && paddr == `RV_A_PC),
		.pc_wdata(pwdata),
		.rs1_idx(dec.rs1), .rs2_idx(dec.rs2), .rd_idx_rd(reg_off[6:2]),
		.rs1_val(rs1_val), .rs2_val(rs2_val), .rd_val(rd_val),
		.pc(pc), .csr(csr), .store(store)
	);

	assign pready  = access & (~instr_wr | v_com);
	assign pslverr = access & instr_wr & v_com & dec_q.illegal;

	always_comb begin
		case (paddr)
			`RV_A_PC:      prdata = pc;
			`RV_A_CSR:     prdata = csr;
			`RV_A_ST_ADDR: prdata = store.addr;
			`RV_A_ST_DATA: prdata = store.data;
			`RV_A_ST_MASK: prdata = {28'b0, store.mask};
			default:       prdata = in_regs ? rd_val : '0; // holes read zero
		endcase
	end

endmodule

`default_nettype wire

// File: sim/rv_ref_model.svh
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// architectural state as the host should see it
rv_exec_pkg::word_t      m_regs [32] = '{default: '0};
rv_exec_pkg::word_t      m_pc = `RV_RESET_PC;
rv_exec_pkg::word_t      m_csr = '0;
rv_exec_pkg::store_rec_t m_store = '0;

function automatic rv_exec_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
		input rv_exec_pkg::word_t a, input rv_exec_pkg::word_t b);
	case (f3)
		3'd0: return alt ? a - b : a + b;
		3'd1: return a << b[4:0];
		3'd2: return {31'b0, $signed(a) < $signed(b)};
		3'd3: return {31'b0, a < b};
		3'd4: return a ^ b;
		3'd5: return alt ? rv_exec_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
		3'd6: return a | b;
		default: return a & b;
	endcase
endfunction

function automatic logic branch_taken(input logic [2:0] f3, input rv_exec_pkg::word_t a,
		input rv_exec_pkg::word_t b);
	case (f3)
		3'd0: return a == b;
		3'd1: return a != b;
		3'd4: return $signed(a) < $signed(b);
		3'd5: return $signed(a) >= $signed(b);
		3'd6: return a < b;
		3'd7: return a >= b;
		default: return 1'b0;
	endcase
endfunction

// applies one instruction to the model, returns 1 when it must be rejected
function automatic logic model_exec(input rv_exec_pkg::word_t ins);
	rv_exec_pkg::word_t a, b, r, nxt, imm_i, imm_s, imm_b, imm_j;
	logic [2:0] f3;
	logic       wr;
	f3    = ins[14:12];
	a     = m_regs[ins[19:15]];
	b     = m_regs[ins[24:20]];
	imm_i = {{20{ins[31]}}, ins[31:20]};
	imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
	imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
	imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
	r     = '0;
	wr    = 1'b1;
	nxt   = m_pc + 32'd4;
	case (ins[6:0])
		7'b0110111: r = {ins[31:12], 12'b0};
		7'b0010111: r = m_pc + {ins[31:12], 12'b0};
		7'b1101111: begin
			r   = m_pc + 32'd4;
			nxt = m_pc + imm_j;
		end
		7'b1100111: begin
			r   = m_pc + 32'd4;
			nxt = (a + imm_i) & ~32'h1;
		end
		7'b1100011: begin
			wr = 1'b0;
			if (branch_taken(f3, a, b)) nxt = m_pc + imm_b;
		end
		7'b0100011: begin
			wr      = 1'b0;
			m_store = '{addr: a + imm_s, data: b,
				mask: (f3 == 3'd0) ? 4'h1 : (f3 == 3'd1) ? 4'h3 : 4'hf};
		end
		7'b0010011: r = alu_ref(f3, f3 == 3'd5 && ins[30], a, imm_i);
		7'b0110011: r = alu_ref(f3, ins[30], a, b);
		7'b1110011: begin
			if (f3 != 3'b001 && f3 != 3'b010) return 1'b1;
			r     = m_csr; // old value to rd
			m_csr = (f3 == 3'b001) ? a : (a | m_csr);
		end
		default: return 1'b1;
	endcase
	if (wr && ins[11:7] != 5'd0) m_regs[ins[11:7]] = r;
	m_pc = nxt;
	return 1'b0;
endfunction

function automatic rv_exec_pkg::word_t gen_alu();
	logic [2:0]  f3;
	logic [11:0] imm;
	logic [9:0]  src;
	logic [4:0]  rd;
	f3  = 3'(next_bits(3));
	imm = 12'(next_bits(12));
	src = 10'(next_bits(10));
	rd  = 5'(next_bits(5));
	if (imm[11]) begin // register form
		return {1'b0, imm[10] && (f3 == 3'd0 || f3 == 3'd5), 5'b0, src, f3, rd, 7'b0110011};
	end
	if (f3 == 3'd1 || f3 == 3'd5) begin
		imm[11:5] = {1'b0, imm[10] && f3 == 3'd5, 5'b0}; // shamt only
	end
	return {imm, src[4:0], f3, rd, 7'b0010011};
endfunction

function automatic rv_exec_pkg::word_t gen_flow();
	logic [2:0]  f3;
	logic [19:0] hi;
	logic [4:0]  rd;
	f3 = 3'(next_bits(3));
	hi = 20'(next_bits(20));
	rd = 5'(next_bits(5));
	if (f3[2:1] == 2'b01) begin // funct3 2 and 3 are no branch
		return f3[0] ? {hi[19:8], hi[7:3], 3'b000, rd, 7'b1100111} : {hi, rd, 7'b1101111};
	end
	return {hi[19:8], hi[7:3], f3, rd, 7'b1100011};
endfunction

function automatic rv_exec_pkg::word_t gen_store();
	rv_exec_pkg::word_t w;
	logic [1:0]         sz;
	w  = next_bits(32);
	sz = 2'(next_bits(2));
	if (sz == 2'd3) sz = 2'd2;
	return {w[31:15], 1'b0, sz, w[11:7], 7'b0100011};
endfunction

function automatic rv_exec_pkg::word_t gen_csr();
	rv_exec_pkg::word_t w;
	w = next_bits(32);
	return {w[31:15], 1'b0, w[12] ? 2'b10 : 2'b01, w[11:7], 7'b1110011};
endfunction

function automatic rv_exec_pkg::word_t gen_illegal();
	rv_exec_pkg::word_t w;
	w = next_bits(32);
	if (w[7]) begin // system with a funct3 that is no csr op
		if (w[13:12] != 2'b00 && !w[14]) w[14] = 1'b1;
		return {w[31:7], 7'b1110011};
	end
	case (w[6:0])
		7'b0110111, 7'b0010111, 7'b1101111, 7'b1100111, 7'b1100011,
		7'b0100011, 7'b0010011, 7'b0110011, 7'b1110011: w[6:0] = 7'b0000011;
		default: w[6:0] = w[6:0];
	endcase
	return w;
endfunction

`endif

// File: sim/rv_exec_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_exec_settings.svh"

module rv_exec_tb;

	localparam int N_ALU     = 200;
	localparam int N_FLOW    = 60;
	localparam int N_STORE   = 40;
	localparam int N_CSR     = 40;
	localparam int N_ILLEGAL = 20;
	localparam int N_ZERO    = 40;
	// apb transfers over the whole run, 62 for the preload, 32 per full register sweep
	localparam int N_XFER = 62 + 2 * N_ALU + 4 * N_FLOW + 4 * N_STORE + 32 + 3 * N_CSR
		+ 2 * N_ILLEGAL + 32 + 2 * N_ZERO;
	localparam int MAX_CYCLES = 4 * N_XFER + 500;

	logic               clk, arst_n, psel, penable, pwrite, pready, pslverr;
	logic [11:0]        paddr;
	rv_exec_pkg::word_t pwdata, prdata;
	logic [31:0]        lfsr = 32'haf25b759;
	int                 cycles = 0;
	int                 checks = 0;
	int                 errors = 0;
	int                 test_no = 1;
	int                 test_checks = 0;
	int                 test_errors = 0;

	rv_exec_top dut_i (
		.clk(clk), .arst_n(arst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: no result after %0d cycles, a transfer never completed", cycles);
			$display("tests failed");
			$finish;
		end
	end

	// fibonacci lfsr, taps 32 22 2 1
	function automatic rv_exec_pkg::word_t next_bits(input int n);
		rv_exec_pkg::word_t v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v    = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	`include "rv_ref_model.svh"

	task automatic check_word(input string what, input rv_exec_pkg::word_t got,
			input rv_exec_pkg::word_t exp);
		test_checks++;
		if (got !== exp) begin
			test_errors++;
			$display("ERR %0t: %s read %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_store(input rv_exec_pkg::store_rec_t got,
			input rv_exec_pkg::store_rec_t exp);
		test_checks++;
		if (got !== exp) begin
			test_errors++;
			$display("ERR %0t: store record %h/%h/%h, expected %h/%h/%h", $time,
				got.addr, got.data, got.mask, exp.addr, exp.data, exp.mask);
		end
	endtask

	task automatic check_resp(input string what, input logic got, input logic exp);
		test_checks++;
		if (got !== exp) begin
			test_errors++;
			$display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// one apb transfer, waits for pready and samples on the falling edge
	task automatic apb_xfer(input logic wr, input logic [11:0] addr,
			input rv_exec_pkg::word_t wdata, output rv_exec_pkg::word_t rdata, output logic err);
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= addr;
		pwdata  <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		while (!pready) @(negedge clk);
		rdata = prdata;
		err   = pslverr;
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic read_word(input logic [11:0] addr, output rv_exec_pkg::word_t data);
		logic err;
		apb_xfer(1'b0, addr, '0, data, err);
		check_resp("pslverr on read", err, 1'b0);
	endtask

	task automatic write_pc(input rv_exec_pkg::word_t value);
		rv_exec_pkg::word_t unused;
		logic               err;
		apb_xfer(1'b1, `RV_A_PC, value, unused, err);
		m_pc = value;
		check_resp("pslverr on pc write", err, 1'b0);
	endtask

	task automatic run_instr(input rv_exec_pkg::word_t ins);
		rv_exec_pkg::word_t unused;
		logic               err, exp_err;
		exp_err = model_exec(ins);
		apb_xfer(1'b1, `RV_A_INSTR, ins, unused, err);
		check_resp($sformatf("pslverr for %h", ins), err, exp_err);
	endtask

	task automatic check_reg(input logic [4:0] i);
		rv_exec_pkg::word_t v;
		read_word(12'(`RV_A_REG_BASE + 4 * i), v);
		check_word($sformatf("x%0d", i), v, m_regs[i]);
	endtask

	task automatic check_all_regs();
		for (int i = 0; i < 32; i++) begin
			check_reg(5'(i));
		end
	endtask

	task automatic check_pc();
		rv_exec_pkg::word_t v;
		read_word(`RV_A_PC, v);
		check_word("pc", v, m_pc);
	endtask

	task automatic check_csr();
		rv_exec_pkg::word_t v;
		read_word(`RV_A_CSR, v);
		check_word("csr", v, m_csr);
	endtask

	task automatic read_store(output rv_exec_pkg::store_rec_t st);
		rv_exec_pkg::word_t v;
		read_word(`RV_A_ST_ADDR, st.addr);
		read_word(`RV_A_ST_DATA, st.data);
		read_word(`RV_A_ST_MASK, v);
		st.mask = v[3:0]; // upper bits read zero
	endtask

	task automatic end_test(input string name);
		$display("test %0d %s: %0d checks, %0d errors", test_no, name, test_checks, test_errors);
		checks      += test_checks;
		errors      += test_errors;
		test_no     += 1;
		test_checks = 0;
		test_errors = 0;
	endtask

	initial begin
		rv_exec_pkg::word_t      ins;
		rv_exec_pkg::store_rec_t st;
		logic [1:0]              sel;
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		paddr   <= '0;
		pwdata  <= '0;
		arst_n  <= 1'b0;
		repeat (2) @(posedge clk);
		arst_n <= 1'b1;

		for (int i = 1; i < 32; i++) begin // lui then addi into every register
			run_instr({20'(next_bits(20)), 5'(i), 7'b0110111});
			run_instr({12'(next_bits(12)), 5'(i), 3'b000, 5'(i), 7'b0010011});
		end
		for (int n = 0; n < N_ALU; n++) begin
			ins = gen_alu();
			run_instr(ins);
			check_reg(ins[11:7]);
		end
		end_test("alu ops");

		for (int n = 0; n < N_FLOW; n++) begin
			write_pc(next_bits(32) & ~32'h3);
			ins = gen_flow();
			run_instr(ins);
			check_pc();
			if (ins[6:0] != 7'b1100011) check_reg(ins[11:7]); // link register
		end
		end_test("branches and jumps");

		for (int n = 0; n < N_STORE; n++) begin
			run_instr(gen_store());
			read_store(st);
			check_store(st, m_store);
		end
		check_all_regs();
		end_test("stores");

		for (int n = 0; n < N_CSR; n++) begin
			ins = gen_csr();
			run_instr(ins);
			check_csr();
			check_reg(ins[11:7]);
		end
		end_test("csr ops");

		for (int n = 0; n < N_ILLEGAL; n++) begin
			run_instr(gen_illegal());
			check_pc();
		end
		check_all_regs();
		end_test("illegal opcodes");

		for (int n = 0; n < N_ZERO; n++) begin
			sel = 2'(next_bits(2));
			case (sel)
				2'd0: ins = gen_alu();
				2'd1: ins = gen_flow();
				2'd2: ins = gen_csr();
				default: ins = {20'(next_bits(20)), 5'd0, 7'b0110111};
			endcase
			ins[11:7] = 5'd0;
			run_instr(ins);
			check_reg(5'd0);
		end
		end_test("writes to x0");

		$display("%0d tests, %0d checks, %0d errors", test_no - 1, checks, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
+incdir+design
+incdir+sim
design/rv_exec_pkg.sv
design/key_mux.sv
design/instr_decode.sv
design/alu_execute.sv
design/result_commit.sv
design/rv_exec_top.sv
sim/rv_exec_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the rv32i execution testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module rv_exec_tb -f project.f -o rv_exec_sim

out=$(./obj_dir/rv_exec_sim)
echo "$out"
echo "$out" | grep -q "all tests passed"
